// File: idStage.f
source/idPkg.sv
source/regFile.sv
source/instrDecoder.sv
source/hazardUnit.sv
source/operandFetch.sv
source/idStage.sv
+incdir+tb
tb/idStageTb.sv

// File: source/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  idPkg::word_t          instruction,
    input  idPkg::decodeInfo_t    info,
    input  idPkg::pipeWriteInfo_t exInfo,
    input  idPkg::pipeWriteInfo_t memInfo,
    output idPkg::idCtrl_t        ctrl,
    output idPkg::fwdSel_t        rsSel,
    output idPkg::fwdSel_t        rtSel,
    output logic                  bubble,
    output logic                  storeDataFromLoad
);

    idPkg::regAddr_t rs;
    idPkg::regAddr_t rt;
    logic            exIsLoad;
    logic            rsLoadHit;
    logic            rtLoadHit;

    // ex has priority, a load in ex cannot forward yet
    function automatic idPkg::fwdSel_t pickSource(
        input idPkg::regAddr_t       src,
        input idPkg::pipeWriteInfo_t ex,
        input idPkg::pipeWriteInfo_t mem
    );
        if (src == '0) begin
            return idPkg::fwdNone;
        end
        if (ex.regWrite && !ex.memToReg && (ex.writeAddr == src)) begin
            return idPkg::fwdExAlu;
        end
        if (mem.regWrite && (mem.writeAddr == src)) begin
            return mem.memToReg ? idPkg::fwdMemData : idPkg::fwdMemAlu;
        end
        return idPkg::fwdNone;
    endfunction

    assign rs = instruction[25:21];
    assign rt = instruction[20:16];

    assign rsSel = pickSource(rs, exInfo, memInfo);
    assign rtSel = pickSource(rt, exInfo, memInfo);

    assign exIsLoad  = exInfo.regWrite && exInfo.memToReg && (exInfo.writeAddr != '0);
    assign rsLoadHit = exIsLoad && info.usesRs && (rs == exInfo.writeAddr);
    assign rtLoadHit = exIsLoad && info.usesRt && (rt == exInfo.writeAddr);

    // sw data from the load ahead goes mem to mem later, no stall
    assign storeDataFromLoad = info.ctrl.memWrite && rtLoadHit && !rsLoadHit;
    assign bubble            = rsLoadHit || (rtLoadHit && !info.ctrl.memWrite);

    always_comb begin
        ctrl = info.ctrl;
        if (bubble) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/idPkg.sv
`default_nettype none

package idPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluSlt  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluPass = 4'd7  // operand A straight through, used by jal
    } aluOp_t;

    typedef enum logic [2:0] {
        brNone = 3'd0,
        brBeq  = 3'd1,
        brBne  = 3'd2,
        brJump = 3'd3,
        brJal  = 3'd4,
        brJr   = 3'd5
    } branchKind_t;

    typedef enum logic [1:0] {
        fwdNone    = 2'd0,
        fwdExAlu   = 2'd1,
        fwdMemAlu  = 2'd2,
        fwdMemData = 2'd3
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memToReg;
        logic   shamtA;     // alu A takes shamt
        logic   useImm;     // alu B takes immediate
        aluOp_t aluOp;
    } idCtrl_t;

    typedef struct packed {
        idCtrl_t     ctrl;
        branchKind_t branchKind;
        logic        usesRs;
        logic        usesRt;
        logic        writeToRt;
        logic        zeroExtend;
    } decodeInfo_t;

    // write info of an instruction further down the pipe
    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        regAddr_t writeAddr;
    } pipeWriteInfo_t;

    typedef struct packed {
        logic     writeEn;
        regAddr_t writeAddr;
        word_t    writeData;
    } wbWrite_t;

    typedef struct packed {
        word_t    operandA;   // rs, or pc4 for jal
        word_t    operandB;   // rt, or zero for jal
        word_t    immediate;
        regAddr_t writeAddr;
        idCtrl_t  ctrl;
    } idExBundle_t;

endpackage

`default_nettype wire

// File: source/idStage.sv
`timescale 1ns/10ps
`default_nettype none

module idStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  idPkg::word_t          pc4,
    input  idPkg::word_t          instruction,
    input  idPkg::wbWrite_t       wb,
    input  idPkg::pipeWriteInfo_t exInfo,
    input  idPkg::pipeWriteInfo_t memInfo,
    input  idPkg::word_t          exAluOut,
    input  idPkg::word_t          memAluOut,
    input  idPkg::word_t          memData,
    output idPkg::idExBundle_t    toEx,
    output idPkg::word_t          jumpOrBranchPc,
    output logic                  shouldJumpOrBranch,
    output logic                  shouldStall,
    output logic                  storeDataFromLoad
);

    idPkg::decodeInfo_t info;
    idPkg::idCtrl_t     ctrl;   // after bubble masking
    idPkg::fwdSel_t     rsSel;
    idPkg::fwdSel_t     rtSel;
    idPkg::word_t       rdataA;
    idPkg::word_t       rdataB;

    regFile regFile_i (
        .clk    (clk),
        .arstN  (arstN),
        .raddrA (instruction[25:21]),
        .raddrB (instruction[20:16]),
        .wb     (wb),
        .rdataA (rdataA),
        .rdataB (rdataB)
    );

    instrDecoder instrDecoder_i (
        .instruction (instruction),
        .info        (info)
    );

    hazardUnit hazardUnit_i (
        .instruction       (instruction),
        .info              (info),
        .exInfo            (exInfo),
        .memInfo           (memInfo),
        .ctrl              (ctrl),
        .rsSel             (rsSel),
        .rtSel             (rtSel),
        .bubble            (shouldStall),
        .storeDataFromLoad (storeDataFromLoad)
    );

    operandFetch operandFetch_i (
        .pc4                (pc4),
        .instruction        (instruction),
        .info               (info),
        .ctrl               (ctrl),
        .bubble             (shouldStall),
        .rsSel              (rsSel),
        .rtSel              (rtSel),
        .rdataA             (rdataA),
        .rdataB             (rdataB),
        .exAluOut           (exAluOut),
        .memAluOut          (memAluOut),
        .memData            (memData),
        .toEx               (toEx),
        .jumpOrBranchPc     (jumpOrBranchPc),
        .shouldJumpOrBranch (shouldJumpOrBranch)
    );

endmodule

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  idPkg::word_t       instruction,
    output idPkg::decodeInfo_t info
);

    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpJ     = 6'h02;
    localparam logic [5:0] OpJal   = 6'h03;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;
    localparam logic [5:0] OpAddi  = 6'h08;
    localparam logic [5:0] OpAndi  = 6'h0c;
    localparam logic [5:0] OpOri   = 6'h0d;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;

    localparam logic [5:0] FnSll = 6'h00;
    localparam logic [5:0] FnSrl = 6'h02;
    localparam logic [5:0] FnJr  = 6'h08;
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnSlt = 6'h2a;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        idPkg::regAddr_t dest;

        info = '0;  // unknown encodings fall out as a nop
        case (opcode)
            OpRType: begin
                info.ctrl.regWrite = 1'b1;
                info.usesRs        = 1'b1;
                info.usesRt        = 1'b1;
                case (funct)
                    FnAdd: info.ctrl.aluOp = idPkg::aluAdd;
                    FnSub: info.ctrl.aluOp = idPkg::aluSub;
                    FnAnd: info.ctrl.aluOp = idPkg::aluAnd;
                    FnOr:  info.ctrl.aluOp = idPkg::aluOr;
                    FnSlt: info.ctrl.aluOp = idPkg::aluSlt;
                    FnSll, FnSrl: begin
                        info.ctrl.aluOp  = (funct == FnSll) ? idPkg::aluSll : idPkg::aluSrl;
                        info.ctrl.shamtA = 1'b1;
                        info.usesRs      = 1'b0;   // shifts read rt only
                    end
                    FnJr: begin
                        info.ctrl.regWrite = 1'b0;
                        info.usesRt        = 1'b0;
                        info.branchKind    = idPkg::brJr;
                    end
                    default: begin
                        info.ctrl.regWrite = 1'b0;
                        info.usesRs        = 1'b0;
                        info.usesRt        = 1'b0;
                    end
                endcase
            end
            OpAddi, OpAndi, OpOri, OpLw: begin
                info.ctrl.regWrite = 1'b1;
                info.ctrl.useImm   = 1'b1;
                info.ctrl.memToReg = (opcode == OpLw);
                info.usesRs        = 1'b1;
                info.writeToRt     = 1'b1;
                info.zeroExtend    = (opcode == OpAndi) || (opcode == OpOri);
                info.ctrl.aluOp    = (opcode == OpAndi) ? idPkg::aluAnd :
                                     (opcode == OpOri)  ? idPkg::aluOr  : idPkg::aluAdd;
            end
            OpSw: begin
                info.ctrl.memWrite = 1'b1;
                info.ctrl.useImm   = 1'b1;
                info.usesRs        = 1'b1;
                info.usesRt        = 1'b1;  // store data
                info.writeToRt     = 1'b1;
            end
            OpBeq, OpBne: begin
                info.ctrl.aluOp = idPkg::aluSub;
                info.usesRs     = 1'b1;
                info.usesRt     = 1'b1;
                info.writeToRt  = 1'b1;
                info.branchKind = (opcode == OpBeq) ? idPkg::brBeq : idPkg::brBne;
            end
            OpJ: info.branchKind = idPkg::brJump;
            OpJal: begin
                info.ctrl.regWrite = 1'b1;
                info.ctrl.aluOp    = idPkg::aluPass;  // link value is pc4
                info.branchKind    = idPkg::brJal;
            end
            default: info = '0;
        endcase

        dest = (info.branchKind == idPkg::brJal) ? 5'd31 :
               info.writeToRt ? instruction[20:16] : instruction[15:11];
        if (dest == '0) begin
            info.ctrl.regWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/operandFetch.sv
`timescale 1ns/10ps
`default_nettype none

module operandFetch (
    input  idPkg::word_t       pc4,
    input  idPkg::word_t       instruction,
    input  idPkg::decodeInfo_t info,
    input  idPkg::idCtrl_t     ctrl,
    input  logic               bubble,
    input  idPkg::fwdSel_t     rsSel,
    input  idPkg::fwdSel_t     rtSel,
    input  idPkg::word_t       rdataA,
    input  idPkg::word_t       rdataB,
    input  idPkg::word_t       exAluOut,
    input  idPkg::word_t       memAluOut,
    input  idPkg::word_t       memData,
    output idPkg::idExBundle_t toEx,
    output idPkg::word_t       jumpOrBranchPc,
    output logic               shouldJumpOrBranch
);

    idPkg::word_t rsVal;
    idPkg::word_t rtVal;
    idPkg::word_t branchTarget;
    idPkg::word_t jumpTarget;
    logic         isJal;
    logic         taken;

    function automatic idPkg::word_t fwdMux(
        input idPkg::fwdSel_t sel,
        input idPkg::word_t   regVal,
        input idPkg::word_t   exAlu,
        input idPkg::word_t   memAlu,
        input idPkg::word_t   memLoad
    );
        case (sel)
            idPkg::fwdExAlu:   return exAlu;
            idPkg::fwdMemAlu:  return memAlu;
            idPkg::fwdMemData: return memLoad;
            default:           return regVal;
        endcase
    endfunction

    assign rsVal = fwdMux(rsSel, rdataA, exAluOut, memAluOut, memData);
    assign rtVal = fwdMux(rtSel, rdataB, exAluOut, memAluOut, memData);

    assign branchTarget = pc4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
    assign jumpTarget   = {pc4[31:28], instruction[25:0], 2'b00};
    assign isJal        = (info.branchKind == idPkg::brJal);

    always_comb begin
        taken          = 1'b0;
        jumpOrBranchPc = branchTarget;
        case (info.branchKind)
            idPkg::brBeq: taken = (rsVal == rtVal);
            idPkg::brBne: taken = (rsVal != rtVal);
            idPkg::brJump, idPkg::brJal: begin
                taken          = 1'b1;
                jumpOrBranchPc = jumpTarget;
            end
            idPkg::brJr: begin
                taken          = 1'b1;
                jumpOrBranchPc = rsVal;
            end
            default: taken = 1'b0;
        endcase
    end

    assign shouldJumpOrBranch = taken && !bubble;  // operands not valid while stalled

    assign toEx.operandA  = isJal ? pc4 : rsVal;
    assign toEx.operandB  = isJal ? '0 : rtVal;
    assign toEx.immediate = {info.zeroExtend ? 16'h0000 : {16{instruction[15]}},
                             instruction[15:0]};
    assign toEx.writeAddr = isJal ? 5'd31 :
                            info.writeToRt ? instruction[20:16] : instruction[15:11];
    assign toEx.ctrl      = ctrl;

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  idPkg::regAddr_t raddrA,
    input  idPkg::regAddr_t raddrB,
    input  idPkg::wbWrite_t wb,
    output idPkg::word_t    rdataA,
    output idPkg::word_t    rdataB
);

    idPkg::word_t regs [1:31];  // r0 has no storage

    logic wbActive;

    assign wbActive = wb.writeEn && (wb.writeAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbActive) begin
            regs[wb.writeAddr] <= wb.writeData;
        end
    end

    // write-through so ID sees the value being written back this cycle
    assign rdataA = (raddrA == '0) ? '0 :
                    (wbActive && (wb.writeAddr == raddrA)) ? wb.writeData :
                    regs[raddrA];

    assign rdataB = (raddrB == '0) ? '0 :
                    (wbActive && (wb.writeAddr == raddrB)) ? wb.writeData :
                    regs[raddrB];

endmodule

`default_nettype wire

// File: tb/idStageVectors.svh
// columns: name, pc4, instruction, wb {en,addr,data}, exInfo, memInfo, exAluOut, memAluOut,
//   memData, expA, expB, expWriteAddr, expCtrl, expPc, flags {taken,stall,sdl,aReg,bReg,zx}
task automatic loadVectors();
    addRow("wbBypass", pcA, rType(5, 6, 7, 0, 6'h20), {1'b1, 5'd5, 32'h1234_5678}, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd7, 9'b1_0_0_0_0_0000, 0, 6'b000110);
    addRow("wbReadBack", pcA, rType(5, 5, 8, 0, 6'h20), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd8, 9'b1_0_0_0_0_0000, 0, 6'b000110);
    addRow("wbR0", pcA, rType(0, 0, 9, 0, 6'h20), {1'b1, 5'd0, 32'hFFFF_FFFF}, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd9, 9'b1_0_0_0_0_0000, 0, 6'b000110);
    addRow("fwdExPriority", pcA, rType(10, 10, 11, 0, 6'h20), noWb, 7'b1_0_01010, 7'b1_0_01010,
        exVal, memVal, loadVal, exVal, exVal, 5'd11, 9'b1_0_0_0_0_0000, 0, 6'b000000);
    addRow("fwdMemAlu", pcA, rType(10, 10, 11, 0, 6'h20), noWb, noFwd, 7'b1_0_01010,
        exVal, memVal, loadVal, memVal, memVal, 5'd11, 9'b1_0_0_0_0_0000, 0, 6'b000000);
    addRow("fwdMemData", pcA, rType(10, 10, 11, 0, 6'h20), noWb, noFwd, 7'b1_1_01010,
        exVal, memVal, loadVal, loadVal, loadVal, 5'd11, 9'b1_0_0_0_0_0000, 0, 6'b000000);
    addRow("fwdNoR0", pcA, rType(0, 12, 11, 0, 6'h20), noWb, 7'b1_0_00000, 7'b1_1_00000,
        exVal, memVal, loadVal, 0, 0, 5'd11, 9'b1_0_0_0_0_0000, 0, 6'b000010);
    addRow("beqTakenBack", pcA, iType(6'h04, 10, 13, 16'hFFFC), noWb, 7'b1_0_01010, 7'b1_0_01101,
        32'h42, 32'h42, loadVal, 32'h42, 32'h42, 5'd13, 9'b0_0_0_0_0_0001, 32'h0040_00F0,
        6'b100000);
    addRow("beqNotTaken", pcA, iType(6'h04, 10, 13, 16'hFFFC), noWb, 7'b1_0_01010, 7'b1_0_01101,
        32'h42, 32'h43, loadVal, 32'h42, 32'h43, 5'd13, 9'b0_0_0_0_0_0001, 0, 6'b000000);
    addRow("bneTakenFwd", pcA, iType(6'h05, 5, 0, 16'h0008), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd0, 9'b0_0_0_0_0_0001, 32'h0040_0120, 6'b100110);
    addRow("bneNotTaken", pcA, iType(6'h05, 0, 0, 16'h0008), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd0, 9'b0_0_0_0_0_0001, 0, 6'b000110);
    addRow("jump", pcB, jType(6'h02, 26'h000_1000), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd2, 9'b0_0_0_0_0_0000, 32'h9000_4000, 6'b100110);
    addRow("jal", pcB, jType(6'h03, 26'h000_1000), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, pcB, 0, 5'd31, 9'b1_0_0_0_0_0111, 32'h9000_4000, 6'b100000);
    addRow("jr", pcA, rType(5, 0, 0, 0, 6'h08), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd0, 9'b0_0_0_0_0_0000, 32'h1234_5678, 6'b100110);
    addRow("jrFwd", pcA, rType(10, 0, 0, 0, 6'h08), noWb, 7'b1_0_01010, noFwd,
        32'h80, memVal, loadVal, 32'h80, 0, 5'd0, 9'b0_0_0_0_0_0000, 32'h80, 6'b100010);
    addRow("loadUseBranch", pcA, iType(6'h04, 10, 10, 16'h0004), noWb, 7'b1_1_01010, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd10, 9'b0_0_0_0_0_0001, 0, 6'b010110);
    addRow("loadUseAdd", pcA, rType(10, 12, 11, 0, 6'h20), noWb, 7'b1_1_01010, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd11, 9'b0_0_0_0_0_0000, 0, 6'b010110);
    addRow("swDataFromLoad", pcA, iType(6'h2b, 5, 10, 16'h0010), noWb, 7'b1_1_01010, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd10, 9'b0_1_0_0_1_0000, 0, 6'b001110);
    addRow("swBaseFromLoad", pcA, iType(6'h2b, 10, 5, 16'h0010), noWb, 7'b1_1_01010, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd5, 9'b0_0_0_0_1_0000, 0, 6'b010110);
    addRow("addi", pcA, iType(6'h08, 5, 16, 16'hFFFF), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd16, 9'b1_0_0_0_1_0000, 0, 6'b000110);
    addRow("andi", pcA, iType(6'h0c, 5, 17, 16'h8001), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd17, 9'b1_0_0_0_1_0010, 0, 6'b000111);
    addRow("ori", pcA, iType(6'h0d, 5, 18, 16'hF0F0), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd18, 9'b1_0_0_0_1_0011, 0, 6'b000111);
    addRow("lw", pcA, iType(6'h23, 5, 19, 16'h8000), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd19, 9'b1_0_1_0_1_0000, 0, 6'b000110);
    addRow("sll", pcA, rType(0, 20, 21, 4, 6'h00), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd21, 9'b1_0_0_1_0_0101, 0, 6'b000110);
    addRow("srl", pcA, rType(0, 20, 22, 4, 6'h02), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd22, 9'b1_0_0_1_0_0110, 0, 6'b000110);
    addRow("sub", pcA, rType(5, 20, 23, 0, 6'h22), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd23, 9'b1_0_0_0_0_0001, 0, 6'b000110);
    addRow("slt", pcA, rType(5, 20, 24, 0, 6'h2a), noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd24, 9'b1_0_0_0_0_0100, 0, 6'b000110);
    addRow("nop", pcA, 32'h0000_0000, noWb, noFwd, noFwd,
        exVal, memVal, loadVal, 0, 0, 5'd0, 9'b0_0_0_1_0_0101, 0, 6'b000110);
endtask

// File: tb/idStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module idStageTb;

    typedef struct {
        string                 name;
        idPkg::word_t          pc4;
        idPkg::word_t          instr;
        idPkg::wbWrite_t       wb;
        idPkg::pipeWriteInfo_t ex;
        idPkg::pipeWriteInfo_t mem;
        idPkg::word_t          exAlu;
        idPkg::word_t          memAlu;
        idPkg::word_t          memLoad;
        idPkg::word_t          expA;
        idPkg::word_t          expB;
        idPkg::regAddr_t       expWa;
        logic [8:0]            expCtrl;
        idPkg::word_t          expPc;
        logic [5:0]            flags;
    } vecRow_t;

    localparam idPkg::word_t pcA     = 32'h0040_0100;
    localparam idPkg::word_t pcB     = 32'h9000_0004;
    localparam idPkg::word_t exVal   = 32'hEEEE_0001;
    localparam idPkg::word_t memVal  = 32'hAAAA_0002;
    localparam idPkg::word_t loadVal = 32'hDDDD_0003;
    localparam logic [37:0]  noWb    = '0;
    localparam logic [6:0]   noFwd   = '0;

    logic clk;
    logic arstN;
    idPkg::word_t          pc4;
    idPkg::word_t          instruction;
    idPkg::wbWrite_t       wb;
    idPkg::pipeWriteInfo_t exInfo;
    idPkg::pipeWriteInfo_t memInfo;
    idPkg::word_t          exAluOut;
    idPkg::word_t          memAluOut;
    idPkg::word_t          memData;
    idPkg::idExBundle_t    toEx;
    idPkg::word_t          jumpOrBranchPc;
    logic shouldJumpOrBranch;
    logic shouldStall;
    logic storeDataFromLoad;

    vecRow_t      rows[$];
    idPkg::word_t regModel [0:31];
    int           passCount;
    int           failCount;
    integer       seed;

    idStage idStage_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        #2 arstN = 1'b1;
    end

    function automatic idPkg::word_t rType(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic idPkg::word_t iType(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic idPkg::word_t jType(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic addRow(input string name, input idPkg::word_t p, input idPkg::word_t i,
                          input logic [37:0] w, input logic [6:0] e, input logic [6:0] m,
                          input idPkg::word_t xa, input idPkg::word_t ma, input idPkg::word_t md,
                          input idPkg::word_t a, input idPkg::word_t b, input logic [4:0] wa,
                          input logic [8:0] c, input idPkg::word_t pc, input logic [5:0] f);
        vecRow_t r;
        r = '{name, p, i, w, e, m, xa, ma, md, a, b, wa, c, pc, f};
        rows.push_back(r);
    endtask

    `include "idStageVectors.svh"

    // register file as seen from ID, including the same-cycle write-back
    function automatic idPkg::word_t modelRead(input logic [4:0] addr, input idPkg::wbWrite_t w);
        if (addr == 0) begin
            return '0;
        end
        if (w.writeEn && w.writeAddr == addr) begin
            return w.writeData;
        end
        return regModel[addr];
    endfunction

    task automatic checkValue(input string test, input string field, input logic [31:0] expVal,
                              input logic [31:0] actVal, inout bit ok);
        if (expVal !== actVal) begin
            if (ok) begin
                $display("FAIL %s %s expected %h actual %h", test, field, expVal, actVal);
            end
            ok = 1'b0;
        end
    endtask

    task automatic nextDrive();
        @(posedge clk);
        #2;
    endtask

    task automatic runRow(input vecRow_t r);
        idPkg::word_t expA;
        idPkg::word_t expB;
        idPkg::word_t expImm;
        bit ok;
        ok = 1'b1;
        nextDrive();
        pc4 = r.pc4;
        instruction = r.instr;
        wb = r.wb;
        exInfo = r.ex;
        memInfo = r.mem;
        exAluOut = r.exAlu;
        memAluOut = r.memAlu;
        memData = r.memLoad;
        expA = r.flags[2] ? modelRead(r.instr[25:21], r.wb) : r.expA;
        expB = r.flags[1] ? modelRead(r.instr[20:16], r.wb) : r.expB;
        expImm = r.flags[0] ? {16'h0000, r.instr[15:0]} : {{16{r.instr[15]}}, r.instr[15:0]};
        #36;  // just before the next edge
        checkValue(r.name, "operandA", expA, toEx.operandA, ok);
        checkValue(r.name, "operandB", expB, toEx.operandB, ok);
        checkValue(r.name, "immediate", expImm, toEx.immediate, ok);
        checkValue(r.name, "writeAddr", r.expWa, toEx.writeAddr, ok);
        checkValue(r.name, "ctrl", r.expCtrl, toEx.ctrl, ok);
        checkValue(r.name, "taken", r.flags[5], shouldJumpOrBranch, ok);
        checkValue(r.name, "stall", r.flags[4], shouldStall, ok);
        checkValue(r.name, "storeDataFromLoad", r.flags[3], storeDataFromLoad, ok);
        if (r.flags[5]) begin
            checkValue(r.name, "jumpOrBranchPc", r.expPc, jumpOrBranchPc, ok);
        end
        if (r.wb.writeEn && r.wb.writeAddr != 0) begin
            regModel[r.wb.writeAddr] = r.wb.writeData;
        end
        if (ok) begin
            $display("PASS %s", r.name);
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    initial begin
        int  cnt;
        bit  ok;
        pc4 = '0;
        instruction = '0;
        wb = '0;
        exInfo = '0;
        memInfo = '0;
        exAluOut = '0;
        memAluOut = '0;
        memData = '0;
        passCount = 0;
        failCount = 0;
        seed = 32'ha5c4_f51f;
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        loadVectors();

        cnt = 0;
        while (!arstN && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (!arstN) begin
            $display("reset was not released within 20 cycles");
            $display("TEST FAILED");
            $finish;
        end else begin
            ok = 1'b1;
            for (int i = 1; i < 32; i++) begin
                nextDrive();
                instruction = rType(i[4:0], i[4:0], 0, 0, 6'h20);
                #36;
                checkValue("resetZero", "operandA", 0, toEx.operandA, ok);
                checkValue("resetZero", "operandB", 0, toEx.operandB, ok);
            end
            if (ok) begin
                $display("PASS resetZero");
                passCount++;
            end else begin
                failCount++;
            end

            // random preload, one register per cycle
            for (int i = 1; i < 32; i++) begin
                nextDrive();
                wb = {1'b1, i[4:0], $random(seed)};
                regModel[i] = wb.writeData;
            end

            foreach (rows[k]) begin
                runRow(rows[k]);
            end

            $display("%0d passed, %0d failed", passCount, failCount);
            if (failCount == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
